// ==== hdl/kdc_pkg.sv ====
package kdc_pkg;

	// ----------------------------------------
	// Command opcodes, data bits 7:5
	// ----------------------------------------
	typedef enum logic [2:0] {
		CMD_MODE       = 3'd0,
		CMD_CLOCK      = 3'd1,
		CMD_READ_FIFO  = 3'd2,
		CMD_READ_DISP  = 3'd3,
		CMD_WRITE_DISP = 3'd4,
		CMD_INHIBIT    = 3'd5,
		CMD_CLEAR      = 3'd6,
		CMD_END_INT    = 3'd7
	} kdc_cmd_e;

	// Keyboard mode, bit 0 decoded scan, bit 2 sensor matrix
	typedef enum logic [2:0] {
		KM_ENC_KEY  = 3'd0,
		KM_DEC_KEY  = 3'd1,
		KM_ENC_SENS = 3'd4,
		KM_DEC_SENS = 3'd5
	} kdc_kbd_mode_e;

	// ----------------------------------------
	// Field constants
	// ----------------------------------------
	// Key code is {ctrl, shift, row[2:0], col[2:0]}
	localparam int KEY_CODE_W = 8;

	// Status word layout, count sits in bits 3:0
	localparam int STAT_FULL_BIT = 4;
	localparam int STAT_OVR_BIT  = 5;
	localparam int STAT_IRQ_BIT  = 7;

	localparam int PRESCALE_W = 13; // Scan clock prescaler

endpackage

// ==== hdl/kdc_scan_if.sv ====
`timescale 1ns/10ps

// Scan timing and synchronized key inputs shared by timer, scanner and display
interface kdc_scan_if;

	logic       scan_ce;  // One clock per scan step
	logic [3:0] scan_idx; // Current digit / row
	logic [7:0] rl;       // Return lines, active low
	logic       shift;
	logic       ctrl;

	modport timer (
		output scan_ce, scan_idx, rl, shift, ctrl
	);

	modport kbd (
		input scan_ce, scan_idx, rl, shift, ctrl
	);

	modport disp (
		input scan_ce, scan_idx
	);

endinterface

// ==== hdl/kdc_scan_timer.sv ====
`timescale 1ns/10ps

module kdc_scan_timer #(
	parameter int CLK_FREQ_HZ  = 50_000_000,
	parameter int SCAN_FREQ_HZ = 10_000
) (
	input  logic                   clk_i,
	input  logic                   rst_i,
	input  kdc_pkg::kdc_kbd_mode_e kbd_mode_i,
	input  logic                   clk_load_lo_i,
	input  logic                   clk_load_hi_i,
	input  logic [15:0]            clk_wdata_i,
	input  logic [7:0]             rl_i,
	input  logic                   shift_i,
	input  logic                   ctrl_i,
	output logic [7:0]             sl_o,
	output logic                   bd_o,
	kdc_scan_if.timer              scan
);

	localparam int PP_DIV = CLK_FREQ_HZ / SCAN_FREQ_HZ - 1;
	localparam logic [kdc_pkg::PRESCALE_W-1:0] PP_RESET = PP_DIV[kdc_pkg::PRESCALE_W-1:0];

	logic [kdc_pkg::PRESCALE_W-1:0] pp_q;     // Prescaler register
	logic [kdc_pkg::PRESCALE_W-1:0] ps_cnt_q;
	logic [kdc_pkg::PRESCALE_W-1:0] reload;
	logic [3:0] idx_q;
	logic       ce;
	logic       ce_d_q;
	logic [9:0] sync_meta_q;
	logic [9:0] sync_q;

	assign ce = (ps_cnt_q == '0);
	// Shortest scan period is two clocks
	assign reload = pp_q | {{(kdc_pkg::PRESCALE_W-1){1'b0}}, (pp_q == '0)};

	// ----------------------------------------
	// Prescaler and scan counter
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pp_q     <= PP_RESET;
			ps_cnt_q <= '0;
			idx_q    <= '0;
			ce_d_q   <= 1'b0;
			sl_o     <= '0;
			bd_o     <= 1'b0;
		end else begin
			if (clk_load_lo_i) pp_q[4:0] <= clk_wdata_i[4:0];
			if (clk_load_hi_i) pp_q[kdc_pkg::PRESCALE_W-1:5] <= clk_wdata_i[15:8];
			ps_cnt_q <= ce ? reload : ps_cnt_q - 1'b1;
			if (ce) idx_q <= idx_q + 4'd1;
			ce_d_q <= ce;
			bd_o   <= ce_d_q; // Blank while lines switch
			if (ce_d_q) begin
				if (kbd_mode_i[0])
					sl_o <= 8'd1 << idx_q[2:0]; // Decoded, one of eight
				else
					sl_o <= {2{idx_q}};
			end
		end
	end

	// Two-flop synchronizer for the key inputs
	always_ff @(posedge clk_i) begin
		sync_meta_q <= {shift_i, ctrl_i, rl_i};
		sync_q      <= sync_meta_q;
	end

	assign scan.scan_ce  = ce;
	assign scan.scan_idx = idx_q;
	assign scan.rl       = sync_q[7:0];
	assign scan.ctrl     = sync_q[8];
	assign scan.shift    = sync_q[9];

	a_ce_single: assert property (@(posedge clk_i) disable iff (rst_i)
		scan.scan_ce |=> !scan.scan_ce);

endmodule

// ==== hdl/kdc_display_ram.sv ====
`timescale 1ns/10ps

module kdc_display_ram (
	input  logic       clk_i,
	input  logic       wr_a_i,
	input  logic       wr_b_i,
	input  logic [3:0] addr_i,
	input  logic [7:0] wdata_i,
	output logic [7:0] rdata_o,
	output logic [3:0] outa_o,
	output logic [3:0] outb_o,
	kdc_scan_if.disp   scan
);

	logic [3:0] ram_a [16];
	logic [3:0] ram_b [16];
	logic       ce_d_q; // Index has settled after scan_ce

	// ----------------------------------------
	// Bus port
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		if (wr_a_i) ram_a[addr_i] <= wdata_i[7:4]; // High nibble
		if (wr_b_i) ram_b[addr_i] <= wdata_i[3:0];
	end

	assign rdata_o = {ram_a[addr_i], ram_b[addr_i]};

	// ----------------------------------------
	// Refresh port
	// ----------------------------------------
	// Lines up with the registered scan lines in the timer
	always_ff @(posedge clk_i) begin
		ce_d_q <= scan.scan_ce;
		if (ce_d_q) begin
			outa_o <= ram_a[scan.scan_idx];
			outb_o <= ram_b[scan.scan_idx];
		end
	end

endmodule

// ==== hdl/kdc_key_scanner.sv ====
`timescale 1ns/10ps

module kdc_key_scanner (
	input  logic                              clk_i,
	input  logic                              rst_i,
	input  kdc_pkg::kdc_kbd_mode_e            kbd_mode_i,
	kdc_scan_if.kbd                           scan,
	output logic                              key_push_o,
	output logic [kdc_pkg::KEY_CODE_W-1:0]    key_code_o,
	input  logic [2:0]                        sens_addr_i,
	output logic [7:0]                        sens_q_o,
	output logic                              sens_chg_o
);

	logic [7:0][7:0] prev_q;     // Lines seen low on the last visit
	logic [7:0][7:0] held_q;     // Keys already reported
	logic [7:0][7:0] sens_ram_q;
	logic [2:0] row;
	logic [7:0] low;
	logic [7:0] cand;
	logic [7:0] first;
	logic [2:0] col;

	// ----------------------------------------
	// Debounce and pick lowest new column
	// ----------------------------------------
	always_comb begin
		row   = scan.scan_idx[2:0];
		low   = ~scan.rl;
		cand  = low & prev_q[row] & ~held_q[row];
		first = cand & (~cand + 8'd1); // Lowest set bit only
		col   = '0;
		for (int i = 7; i >= 0; i--) begin
			if (cand[i]) col = 3'(i);
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			prev_q     <= '0;
			held_q     <= '0;
			sens_ram_q <= '0;
			key_push_o <= 1'b0;
			sens_chg_o <= 1'b0;
		end else begin
			key_push_o <= 1'b0;
			sens_chg_o <= 1'b0;
			if (scan.scan_ce) begin
				if (kbd_mode_i[2]) begin
					// Sensor matrix, store row and flag any change
					sens_ram_q[row] <= low;
					sens_chg_o      <= (low != sens_ram_q[row]);
				end else begin
					prev_q[row] <= low;
					held_q[row] <= (held_q[row] & low) | first; // Release on high
					key_push_o  <= (cand != '0);
				end
			end
		end
	end

	// Code is latched with the push
	always_ff @(posedge clk_i) begin
		if (scan.scan_ce && cand != '0)
			key_code_o <= {scan.ctrl, scan.shift, row, col};
	end

	assign sens_q_o = sens_ram_q[sens_addr_i];

endmodule

// ==== hdl/kdc_key_fifo.sv ====
`timescale 1ns/10ps

module kdc_key_fifo #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                           clk_i,
	input  logic                           rst_i,
	input  logic                           push_i,
	input  logic [kdc_pkg::KEY_CODE_W-1:0] data_i,
	input  logic                           pop_i,
	input  logic                           clr_i,
	output logic [kdc_pkg::KEY_CODE_W-1:0] q_o,
	output logic [4:0]                     count_o,
	output logic                           ovr_o
);

	localparam int AW = $clog2(FIFO_DEPTH);

	logic [kdc_pkg::KEY_CODE_W-1:0] mem_q [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr_q;
	logic [AW-1:0] rd_ptr_q;
	logic          full;
	logic          do_push;
	logic          do_pop;

	assign full    = (count_o == 5'(FIFO_DEPTH));
	assign do_push = push_i & ~full;
	assign do_pop  = pop_i & (count_o != '0);

	always_ff @(posedge clk_i) begin
		if (rst_i || clr_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_o  <= '0;
			ovr_o    <= 1'b0;
		end else begin
			if (do_push) wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
			if (do_push && !do_pop)      count_o <= count_o + 5'd1;
			else if (do_pop && !do_push) count_o <= count_o - 5'd1;
			if (push_i && full) ovr_o <= 1'b1; // Sticky until clear
		end
	end

	always_ff @(posedge clk_i) begin
		if (do_push) mem_q[wr_ptr_q] <= data_i;
	end

	assign q_o = mem_q[rd_ptr_q]; // Oldest entry

	a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i)
		pop_i |-> count_o != '0);

endmodule

// ==== hdl/kdc_cmd_regs.sv ====
`timescale 1ns/10ps

module kdc_cmd_regs #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                           clk_i,
	input  logic                           rst_i,
	input  logic                           cyc_i,
	input  logic                           stb_i,
	input  logic                           we_i,
	input  logic [1:0]                     sel_i,
	input  logic                           adr_i,
	input  logic [15:0]                    dat_i,
	output logic                           ack_o,
	output logic [15:0]                    dat_o,
	output kdc_pkg::kdc_kbd_mode_e         kbd_mode_o,
	output logic                           clk_load_lo_o,
	output logic                           clk_load_hi_o,
	output logic [15:0]                    clk_wdata_o,
	output logic                           disp_wr_a_o,
	output logic                           disp_wr_b_o,
	output logic [3:0]                     disp_addr_o,
	output logic [7:0]                     disp_wdata_o,
	input  logic [7:0]                     disp_rdata_i,
	output logic                           fifo_pop_o,
	output logic                           fifo_clr_o,
	input  logic [kdc_pkg::KEY_CODE_W-1:0] fifo_q_i,
	input  logic [4:0]                     fifo_count_i,
	input  logic                           fifo_ovr_i,
	output logic [2:0]                     sens_addr_o,
	input  logic [7:0]                     sens_q_i,
	input  logic                           sens_chg_i,
	output logic                           irq_o
);

	kdc_pkg::kdc_cmd_e cmd;
	logic       start;
	logic       cmd_wr;
	logic       data_wr;
	logic       data_rd;
	logic       sensor;
	logic       addr_inc;
	logic       read_disp_q; // Data reads from display RAM, else FIFO
	logic       ai_q;        // Auto-increment
	logic [3:0] addr_q;
	logic       inh_a_q;
	logic       inh_b_q;
	logic       sens_irq_q;
	logic [7:0] status;
	logic [7:0] rd_data;

	// ----------------------------------------
	// Bus decode
	// ----------------------------------------
	assign start   = cyc_i & stb_i & ~ack_o; // One action per transaction
	assign cmd     = kdc_pkg::kdc_cmd_e'(dat_i[7:5]);
	assign cmd_wr  = start & we_i & adr_i;
	assign data_wr = start & we_i & ~adr_i;
	assign data_rd = start & ~we_i & ~adr_i;
	assign sensor  = kbd_mode_o[2];

	assign clk_load_lo_o = cmd_wr & (cmd == kdc_pkg::CMD_CLOCK) & sel_i[0];
	assign clk_load_hi_o = cmd_wr & (cmd == kdc_pkg::CMD_CLOCK) & sel_i[1];
	assign clk_wdata_o   = dat_i;
	assign fifo_clr_o    = cmd_wr & (cmd == kdc_pkg::CMD_CLEAR);

	assign disp_wr_a_o  = data_wr & sel_i[0] & ~inh_a_q;
	assign disp_wr_b_o  = data_wr & sel_i[0] & ~inh_b_q;
	assign disp_addr_o  = addr_q;
	assign disp_wdata_o = dat_i[7:0];
	assign sens_addr_o  = addr_q[2:0];

	assign fifo_pop_o = data_rd & ~read_disp_q & ~sensor & (fifo_count_i != '0);
	assign addr_inc   = ai_q & (data_wr | (data_rd & (read_disp_q | sensor)));

	// Keyboard irq follows the FIFO, sensor irq is held until end-interrupt
	assign irq_o = sensor ? sens_irq_q : (fifo_count_i != '0);

	always_comb begin
		status = '0;
		status[3:0] = fifo_count_i[3:0];
		status[kdc_pkg::STAT_FULL_BIT] = (fifo_count_i == 5'(FIFO_DEPTH));
		status[kdc_pkg::STAT_OVR_BIT]  = fifo_ovr_i;
		status[kdc_pkg::STAT_IRQ_BIT]  = irq_o;
		if (read_disp_q)  rd_data = disp_rdata_i;
		else if (sensor)  rd_data = sens_q_i;
		else              rd_data = fifo_q_i;
	end

	// ----------------------------------------
	// Command registers
	// ----------------------------------------
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			ack_o       <= 1'b0;
			kbd_mode_o  <= kdc_pkg::KM_ENC_KEY;
			read_disp_q <= 1'b0;
			ai_q        <= 1'b0;
			addr_q      <= '0;
			inh_a_q     <= 1'b0;
			inh_b_q     <= 1'b0;
			sens_irq_q  <= 1'b0;
		end else begin
			ack_o <= start;
			if (addr_inc) addr_q <= addr_q + 4'd1;
			if (cmd_wr) begin
				case (cmd)
					kdc_pkg::CMD_MODE:
						if (sel_i[0]) kbd_mode_o <= kdc_pkg::kdc_kbd_mode_e'(dat_i[2:0]);
					kdc_pkg::CMD_READ_FIFO: begin
						read_disp_q <= 1'b0;
						addr_q      <= {1'b0, dat_i[2:0]}; // Sensor row
						ai_q        <= dat_i[4];
					end
					kdc_pkg::CMD_READ_DISP: begin
						read_disp_q <= 1'b1;
						addr_q      <= dat_i[3:0];
						ai_q        <= dat_i[4];
					end
					kdc_pkg::CMD_WRITE_DISP: begin
						addr_q <= dat_i[3:0];
						ai_q   <= dat_i[4];
					end
					kdc_pkg::CMD_INHIBIT: begin
						inh_a_q <= dat_i[2];
						inh_b_q <= dat_i[3];
					end
					kdc_pkg::CMD_END_INT: sens_irq_q <= 1'b0;
					default: ; // Clock and clear act through strobes
				endcase
			end
			if (sens_chg_i) sens_irq_q <= 1'b1; // New change wins over end-interrupt
		end
	end

	always_ff @(posedge clk_i) begin
		if (start && !we_i)
			dat_o <= {8'h00, adr_i ? status : rd_data};
	end

	a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_o |=> !ack_o);

endmodule

// ==== hdl/kbd_disp_ctrl.sv ====
`timescale 1ns/10ps

module kbd_disp_ctrl #(
	parameter int CLK_FREQ_HZ  = 50_000_000,
	parameter int SCAN_FREQ_HZ = 10_000,
	parameter int FIFO_DEPTH   = 8
) (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [1:0]  sel_i,
	input  logic        adr_i,
	input  logic [15:0] dat_i,
	output logic        ack_o,
	output logic [15:0] dat_o,
	output logic [7:0]  sl_o,
	input  logic [7:0]  rl_i,
	input  logic        shift_i,
	input  logic        ctrl_i,
	output logic [3:0]  outa_o,
	output logic [3:0]  outb_o,
	output logic        bd_o,
	output logic        irq_o
);

	kdc_pkg::kdc_kbd_mode_e kbd_mode;
	logic        clk_load_lo;
	logic        clk_load_hi;
	logic [15:0] clk_wdata;
	logic        disp_wr_a;
	logic        disp_wr_b;
	logic [3:0]  disp_addr;
	logic [7:0]  disp_wdata;
	logic [7:0]  disp_rdata;
	logic        key_push;
	logic [kdc_pkg::KEY_CODE_W-1:0] key_code;
	logic [kdc_pkg::KEY_CODE_W-1:0] fifo_q;
	logic        fifo_pop;
	logic        fifo_clr;
	logic [4:0]  fifo_count;
	logic        fifo_ovr;
	logic [2:0]  sens_addr;
	logic [7:0]  sens_q;
	logic        sens_chg;

	kdc_scan_if scan_if_i ();

	// ----------------------------------------
	// Scan side
	// ----------------------------------------
	kdc_scan_timer #(
		.CLK_FREQ_HZ  (CLK_FREQ_HZ),
		.SCAN_FREQ_HZ (SCAN_FREQ_HZ)
	) scan_timer_i (
		.clk_i, .rst_i,
		.kbd_mode_i    (kbd_mode),
		.clk_load_lo_i (clk_load_lo),
		.clk_load_hi_i (clk_load_hi),
		.clk_wdata_i   (clk_wdata),
		.rl_i, .shift_i, .ctrl_i, .sl_o, .bd_o,
		.scan          (scan_if_i.timer)
	);

	kdc_display_ram display_ram_i (
		.clk_i,
		.wr_a_i  (disp_wr_a),
		.wr_b_i  (disp_wr_b),
		.addr_i  (disp_addr),
		.wdata_i (disp_wdata),
		.rdata_o (disp_rdata),
		.outa_o, .outb_o,
		.scan    (scan_if_i.disp)
	);

	kdc_key_scanner key_scanner_i (
		.clk_i, .rst_i,
		.kbd_mode_i  (kbd_mode),
		.scan        (scan_if_i.kbd),
		.key_push_o  (key_push),
		.key_code_o  (key_code),
		.sens_addr_i (sens_addr),
		.sens_q_o    (sens_q),
		.sens_chg_o  (sens_chg)
	);

	kdc_key_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) key_fifo_i (
		.clk_i, .rst_i,
		.push_i  (key_push),
		.data_i  (key_code),
		.pop_i   (fifo_pop),
		.clr_i   (fifo_clr),
		.q_o     (fifo_q),
		.count_o (fifo_count),
		.ovr_o   (fifo_ovr)
	);

	// ----------------------------------------
	// Bus side
	// ----------------------------------------
	kdc_cmd_regs #(.FIFO_DEPTH(FIFO_DEPTH)) cmd_regs_i (
		.clk_i, .rst_i, .cyc_i, .stb_i, .we_i, .sel_i, .adr_i, .dat_i, .ack_o, .dat_o,
		.kbd_mode_o    (kbd_mode),
		.clk_load_lo_o (clk_load_lo),
		.clk_load_hi_o (clk_load_hi),
		.clk_wdata_o   (clk_wdata),
		.disp_wr_a_o   (disp_wr_a),
		.disp_wr_b_o   (disp_wr_b),
		.disp_addr_o   (disp_addr),
		.disp_wdata_o  (disp_wdata),
		.disp_rdata_i  (disp_rdata),
		.fifo_pop_o    (fifo_pop),
		.fifo_clr_o    (fifo_clr),
		.fifo_q_i      (fifo_q),
		.fifo_count_i  (fifo_count),
		.fifo_ovr_i    (fifo_ovr),
		.sens_addr_o   (sens_addr),
		.sens_q_i      (sens_q),
		.sens_chg_i    (sens_chg),
		.irq_o
	);

endmodule

// ==== verif/kdc_tb.sv ====
`timescale 1ns/10ps

module kdc_tb;

	localparam int SEED = 32'h5cfe58b7;

	logic        clk_i;
	logic        rst_i   = 1'b1;
	logic        cyc_i   = 1'b0;
	logic        stb_i   = 1'b0;
	logic        we_i    = 1'b0;
	logic [1:0]  sel_i   = 2'b00;
	logic        adr_i   = 1'b0;
	logic [15:0] dat_i   = '0;
	logic [7:0]  rl_i    = 8'hff;
	logic        shift_i = 1'b0;
	logic        ctrl_i  = 1'b0;
	logic        ack_o;
	logic [15:0] dat_o;
	logic [7:0]  sl_o;
	logic [3:0]  outa_o;
	logic [3:0]  outb_o;
	logic        bd_o;
	logic        irq_o;

	// Reference model state
	logic [3:0] ram_a [16];
	logic [3:0] ram_b [16];
	logic [7:0] sens_pat [8];
	logic [7:0] code_q [$];
	logic [7:0] last_sl   = '0;
	logic       key_down  = 1'b0;
	logic [2:0] key_row   = '0;
	logic [2:0] key_col   = '0;
	logic       decoded   = 1'b0;
	logic       sensor_on = 1'b0;
	int errs = 0;
	int err_mark = 0;
	int checks = 0;
	int tests_run = 0;
	int tests_failed = 0;

	kbd_disp_ctrl #(
		.CLK_FREQ_HZ  (1000),
		.SCAN_FREQ_HZ (100),
		.FIFO_DEPTH   (8)
	) kbd_disp_ctrl_i (.*);

	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	// ----------------------------------------
	// Key and sensor matrix
	// ----------------------------------------
	function automatic logic [2:0] sl_row(input logic [7:0] sl, input logic dec);
		logic [2:0] r;
		r = sl[2:0];
		if (dec) begin
			for (int i = 0; i < 8; i++)
				if (sl[i]) r = 3'(i); // One-hot scan line
		end
		return r;
	endfunction

	always @(negedge clk_i) begin
		if (sensor_on)
			rl_i <= ~sens_pat[sl_row(sl_o, decoded)];
		else if (key_down && sl_row(sl_o, decoded) == key_row)
			rl_i <= ~(8'd1 << key_col);
		else
			rl_i <= 8'hff;
	end

	// ----------------------------------------
	// Checks and bus tasks
	// ----------------------------------------
	task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errs++;
			$display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errs == err_mark) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, errs - err_mark);
		end
		err_mark = errs;
	endtask

	// Called on a falling edge, returns on the falling edge that shows ack
	task automatic bus_xfer(input logic we, input logic adr, input logic [15:0] wdata,
			output logic [15:0] rdata);
		int n;
		n = 0;
		cyc_i = 1'b1;
		stb_i = 1'b1;
		we_i  = we;
		adr_i = adr;
		sel_i = 2'b11;
		dat_i = wdata;
		do begin
			@(negedge clk_i);
			n++;
		end while (!ack_o && n < 20);
		if (!ack_o) begin
			errs++;
			$display("Bus timeout, no ack_o within 20 clock cycles");
		end
		rdata = dat_o;
		cyc_i = 1'b0;
		stb_i = 1'b0;
		we_i  = 1'b0;
	endtask

	task automatic write_cmd(input kdc_pkg::kdc_cmd_e op, input logic [4:0] arg);
		logic [15:0] rd;
		bus_xfer(1'b1, 1'b1, {8'h00, op, arg}, rd);
	endtask

	task automatic data_write(input logic [7:0] d);
		logic [15:0] rd;
		bus_xfer(1'b1, 1'b0, {8'h00, d}, rd);
	endtask

	task automatic wait_sl_change(output int ncyc);
		ncyc = 0;
		do begin
			@(negedge clk_i);
			ncyc++;
		end while (sl_o == last_sl && ncyc < 100);
		if (sl_o == last_sl) begin
			errs++;
			$display("Scan timeout, sl_o did not change within 100 clock cycles");
		end
		last_sl = sl_o;
	endtask

	task automatic wait_steps(input int steps);
		int n;
		repeat (steps) wait_sl_change(n);
	endtask

	// Hold for three rows rounds, then two rounds released
	task automatic press_key(input logic [2:0] row, input logic [2:0] col,
			input logic sh, input logic ct);
		shift_i  = sh;
		ctrl_i   = ct;
		key_row  = row;
		key_col  = col;
		key_down = 1'b1;
		code_q.push_back({ct, sh, row, col});
		wait_steps(24);
		key_down = 1'b0;
		wait_steps(16);
	endtask

	// ----------------------------------------
	// Test sequence
	// ----------------------------------------
	initial begin
		logic [15:0] rd;
		logic [7:0]  d;
		logic [3:0]  a;
		logic [3:0]  start;
		logic [3:0]  idx;
		logic        inh_b;
		int          n;
		int          pp;

		void'($urandom(SEED));
		repeat (5) @(negedge clk_i);
		rst_i = 1'b0;

		check("ack_o", 16'(ack_o), 16'h0);
		check("irq_o", 16'(irq_o), 16'h0);
		check("bd_o", 16'(bd_o), 16'h0);
		bus_xfer(1'b0, 1'b1, 16'h0, rd);
		check("status", rd, 16'h0);
		finish_test("reset values");

		write_cmd(kdc_pkg::CMD_WRITE_DISP, 5'h10); // Auto-increment from 0
		for (int i = 0; i < 16; i++) begin
			d = 8'($urandom);
			data_write(d);
			ram_a[i] = d[7:4];
			ram_b[i] = d[3:0];
		end
		inh_b = 1'($urandom);
		write_cmd(kdc_pkg::CMD_INHIBIT, {1'b0, inh_b, ~inh_b, 2'b00});
		start = 4'($urandom);
		write_cmd(kdc_pkg::CMD_WRITE_DISP, {1'b1, start});
		for (int i = 0; i < 16; i++) begin
			a = start + 4'(i); // Pointer wraps at 16
			d = 8'($urandom);
			data_write(d);
			if (inh_b)
				ram_a[a] = d[7:4];
			else
				ram_b[a] = d[3:0];
		end
		write_cmd(kdc_pkg::CMD_INHIBIT, 5'h00);
		write_cmd(kdc_pkg::CMD_READ_DISP, 5'h10);
		for (int i = 0; i < 16; i++) begin
			bus_xfer(1'b0, 1'b0, 16'h0, rd);
			check("display data", rd, {8'h00, ram_a[i], ram_b[i]});
		end
		finish_test("display write and read");

		wait_sl_change(n); // Line up with the scan
		for (int i = 0; i < 40; i++) begin
			idx = sl_o[3:0] + 4'd1; // Encoded scan steps by one
			wait_sl_change(n);
			check("sl_o", 16'(sl_o), {8'h00, idx, idx});
			check("bd_o", 16'(bd_o), 16'h1);
			check("outa_o", 16'(outa_o), 16'(ram_a[sl_o[3:0]]));
			check("outb_o", 16'(outb_o), 16'(ram_b[sl_o[3:0]]));
			@(negedge clk_i);
			check("bd_o", 16'(bd_o), 16'h0); // Blank lasts one clock
		end
		pp = 3 + $urandom % 7;
		write_cmd(kdc_pkg::CMD_CLOCK, 5'(pp));
		wait_steps(2); // Old countdown runs out first
		for (int i = 0; i < 4; i++) begin
			wait_sl_change(n);
			check("scan interval", 16'(n), 16'(pp + 1));
		end
		finish_test("refresh and scan clock");

		write_cmd(kdc_pkg::CMD_READ_FIFO, 5'h00);
		for (int m = 0; m < 2; m++) begin
			decoded = (m == 0);
			write_cmd(kdc_pkg::CMD_MODE,
				{2'b00, decoded ? kdc_pkg::KM_DEC_KEY : kdc_pkg::KM_ENC_KEY});
			wait_steps(16);
			for (int k = 0; k < 3; k++) begin
				press_key(3'($urandom), 3'($urandom), 1'($urandom), 1'($urandom));
				check("irq_o", 16'(irq_o), 16'h1);
				bus_xfer(1'b0, 1'b0, 16'h0, rd);
				check("key code", rd, {8'h00, code_q.pop_front()});
				check("irq_o", 16'(irq_o), 16'h0);
			end
		end
		finish_test("key scan");

		for (int k = 0; k < 10; k++)
			press_key(3'($urandom), 3'($urandom), 1'($urandom), 1'($urandom));
		bus_xfer(1'b0, 1'b1, 16'h0, rd);
		check("status", rd, 16'h0008 | (16'h1 << kdc_pkg::STAT_FULL_BIT)
			| (16'h1 << kdc_pkg::STAT_OVR_BIT) | (16'h1 << kdc_pkg::STAT_IRQ_BIT));
		write_cmd(kdc_pkg::CMD_CLEAR, 5'h00);
		bus_xfer(1'b0, 1'b1, 16'h0, rd);
		check("status", rd, 16'h0);
		code_q.delete();
		finish_test("fifo overrun and clear");

		for (int r = 0; r < 8; r++)
			sens_pat[r] = 8'($urandom);
		sens_pat[0][0] = 1'b1; // At least one row differs from reset
		decoded   = 1'b0;
		sensor_on = 1'b1;
		write_cmd(kdc_pkg::CMD_MODE, {2'b00, kdc_pkg::KM_ENC_SENS});
		wait_steps(24);
		check("irq_o", 16'(irq_o), 16'h1);
		write_cmd(kdc_pkg::CMD_READ_FIFO, 5'h10);
		for (int r = 0; r < 8; r++) begin
			bus_xfer(1'b0, 1'b0, 16'h0, rd);
			check("sensor row", rd, {8'h00, sens_pat[r]});
		end
		write_cmd(kdc_pkg::CMD_END_INT, 5'h00);
		check("irq_o", 16'(irq_o), 16'h0);
		finish_test("sensor matrix");

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errs);
		if (errs == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== all.f ====
hdl/kdc_pkg.sv
hdl/kdc_scan_if.sv
hdl/kdc_scan_timer.sv
hdl/kdc_display_ram.sv
hdl/kdc_key_scanner.sv
hdl/kdc_key_fifo.sv
hdl/kdc_cmd_regs.sv
hdl/kbd_disp_ctrl.sv
verif/kdc_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= kdc_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
